/* verilog/cache_pkg.sv */
package cache_pkg;

  // Processor word address, top bit selects the control registers
  localparam int ADDR_W      = 16;
  localparam int MEM_ADDR_W  = 15;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int INDEX_W     = 6;
  localparam int TAG_W       = MEM_ADDR_W - INDEX_W;
  localparam int LINES       = 2 ** INDEX_W;
  localparam int CTRL_ADDR_W = 2;
  localparam int CNT_W       = 16;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [STRB_W-1:0]      strb_t;
  typedef logic [TAG_W-1:0]       tag_t;
  typedef logic [INDEX_W-1:0]     index_t;
  typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [CNT_W-1:0]       cnt_t;

  // Control register map
  localparam ctrl_addr_t CTRL_HIT_CNT    = 2'd0;
  localparam ctrl_addr_t CTRL_MISS_CNT   = 2'd1;
  localparam ctrl_addr_t CTRL_INVALIDATE = 2'd2;
  localparam ctrl_addr_t CTRL_CNT_CLEAR  = 2'd3;

  // Accepted data request, nonzero wstrb means write
  typedef struct packed {
    mem_addr_t addr;
    data_t     wdata;
    strb_t     wstrb;
  } cache_req_t;

  // Single-word access to external memory
  typedef struct packed {
    mem_addr_t addr;
    data_t     wdata;
    strb_t     wstrb;
    logic      we;
  } mem_req_t;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    FETCH,
    WRITE
  } cache_state_e;

endpackage

/* verilog/cache_front_end.sv */
module cache_front_end import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Processor bus
  input  logic       iob_valid_i,
  input  addr_t      iob_addr_i,
  input  data_t      iob_wdata_i,
  input  strb_t      iob_wstrb_i,
  output logic       iob_rvalid_o,
  output data_t      iob_rdata_o,
  output logic       iob_ready_o,
  // Cache memory side
  output logic       data_req_o,
  output cache_req_t data_o,
  input  data_t      data_rdata_i,
  input  logic       data_ack_i,
  // Control block side
  output logic       ctrl_req_o,
  output ctrl_addr_t ctrl_addr_o,
  output logic       ctrl_we_o,
  output data_t      ctrl_wdata_o,
  input  data_t      ctrl_rdata_i,
  input  logic       ctrl_ack_i
);

  logic pending_q;
  logic we_q;
  logic ack;
  logic accept;
  logic sel_ctrl;

  // Top address bit picks the register bank
  assign sel_ctrl = iob_addr_i[ADDR_W-1];
  assign ack      = data_ack_i | ctrl_ack_i;

  // Free when idle, or when the pending request finishes this cycle
  assign iob_ready_o = ~pending_q | ack;
  assign accept      = iob_valid_i & iob_ready_o;

  assign data_req_o = accept & ~sel_ctrl;
  assign ctrl_req_o = accept & sel_ctrl;

  // Control access is answered next cycle, so these go straight through
  assign ctrl_addr_o  = iob_addr_i[CTRL_ADDR_W-1:0];
  assign ctrl_we_o    = |iob_wstrb_i;
  assign ctrl_wdata_o = iob_wdata_i;

  // Writes finish silently
  assign iob_rvalid_o = ack & ~we_q;
  assign iob_rdata_o  = ctrl_ack_i ? ctrl_rdata_i : data_rdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      if (accept) begin
        pending_q <= 1'b1;
        we_q      <= |iob_wstrb_i;
      end else if (ack) begin
        pending_q <= 1'b0;
      end
    end
  end

  // Request held for the cache for the whole transaction
  always_ff @(posedge clk_i) begin
    if (data_req_o) begin
      data_o.addr  <= iob_addr_i[MEM_ADDR_W-1:0];
      data_o.wdata <= iob_wdata_i;
      data_o.wstrb <= iob_wstrb_i;
    end
  end

endmodule

/* verilog/cache_memory.sv */
module cache_memory import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Front end
  input  logic       data_req_i,
  input  cache_req_t data_i,
  output logic       data_ack_o,
  output data_t      data_rdata_o,
  // Back end
  output logic       be_req_o,
  output mem_req_t   be_o,
  input  logic       be_ack_i,
  input  data_t      be_rdata_i,
  // Control block
  input  logic       invalidate_i,
  output logic       hit_o,
  output logic       miss_o
);

  cache_state_e state_q;
  cache_state_e state_d;

  logic [LINES-1:0] valid_q;
  tag_t             tag_mem  [LINES];
  data_t            data_mem [LINES];

  index_t index;
  tag_t   tag;
  logic   is_write;
  logic   hit;
  logic   fill;
  logic   update;
  data_t  merged;

  // Direct-mapped split of the word address
  assign index    = data_i.addr[INDEX_W-1:0];
  assign tag      = data_i.addr[MEM_ADDR_W-1:INDEX_W];
  assign is_write = |data_i.wstrb;
  assign hit      = valid_q[index] && (tag_mem[index] == tag);

  // Write data merged over the cached word under the byte strobes
  always_comb begin
    merged = data_mem[index];
    for (int b = 0; b < STRB_W; b++) begin
      if (data_i.wstrb[b]) begin
        merged[8*b +: 8] = data_i.wdata[8*b +: 8];
      end
    end
  end

  always_comb begin
    state_d    = state_q;
    data_ack_o = 1'b0;
    hit_o      = 1'b0;
    miss_o     = 1'b0;
    fill       = 1'b0;
    update     = 1'b0;
    case (state_q)
      IDLE: begin
        if (data_req_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (is_write) begin
          // no allocate on a write miss
          update  = hit;
          state_d = WRITE;
        end else if (hit) begin
          hit_o      = 1'b1;
          data_ack_o = 1'b1;
          state_d    = data_req_i ? LOOKUP : IDLE;
        end else begin
          miss_o  = 1'b1;
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (be_ack_i) begin
          fill       = 1'b1;
          data_ack_o = 1'b1;
          state_d    = data_req_i ? LOOKUP : IDLE;
        end
      end
      WRITE: begin
        // Write-through completes on the memory ack
        if (be_ack_i) begin
          data_ack_o = 1'b1;
          state_d    = data_req_i ? LOOKUP : IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Fetched word goes straight back to the processor
  assign data_rdata_o = (state_q == FETCH) ? be_rdata_i : data_mem[index];

  // Back end request held until its ack
  assign be_req_o    = (state_q == FETCH) || (state_q == WRITE);
  assign be_o.addr   = data_i.addr;
  assign be_o.wdata  = data_i.wdata;
  assign be_o.wstrb  = data_i.wstrb;
  assign be_o.we     = (state_q == WRITE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Invalidate wins over a fill
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (invalidate_i) begin
      valid_q <= '0;
    end else if (fill) begin
      valid_q[index] <= 1'b1;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk_i) begin
    if (fill) begin
      tag_mem[index]  <= tag;
      data_mem[index] <= be_rdata_i;
    end else if (update) begin
      data_mem[index] <= merged;
    end
  end

endmodule

/* verilog/cache_back_end.sv */
module cache_back_end import cache_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Cache memory side
  input  logic     be_req_i,
  input  mem_req_t be_i,
  output logic     be_ack_o,
  output data_t    be_rdata_o,
  // External memory
  output logic     mem_req_o,
  output mem_req_t mem_o,
  input  logic     mem_ack_i,
  input  data_t    mem_rdata_i
);

  logic     busy_q;
  logic     ack_q;
  mem_req_t req_q;
  data_t    rdata_q;
  logic     start;
  logic     done;

  // Cache still holds its request in the ack cycle, so skip that one
  assign start = be_req_i & ~busy_q & ~ack_q;
  assign done  = busy_q & mem_ack_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= done;
      if (start) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Latched request and captured read word
  always_ff @(posedge clk_i) begin
    if (start) begin
      req_q <= be_i;
    end
    if (done) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_o  = busy_q;
  assign mem_o      = req_q;
  assign be_ack_o   = ack_q;
  assign be_rdata_o = rdata_q;

endmodule

/* verilog/cache_control.sv */
module cache_control import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  // Register access strobe from the front end
  input  logic       ctrl_req_i,
  input  ctrl_addr_t ctrl_addr_i,
  input  logic       ctrl_we_i,
  input  data_t      ctrl_wdata_i,
  output logic       ctrl_ack_o,
  output data_t      ctrl_rdata_o,
  // Cache memory events
  input  logic       hit_i,
  input  logic       miss_i,
  output logic       invalidate_o
);

  cnt_t  hit_cnt_q;
  cnt_t  miss_cnt_q;
  cnt_t  hit_cnt_d;
  cnt_t  miss_cnt_d;
  logic  wr;
  logic  clear;
  data_t rdata;

  assign wr    = ctrl_req_i & ctrl_we_i;
  assign clear = wr && (ctrl_addr_i == CTRL_CNT_CLEAR);

  // Saturating event counters
  always_comb begin
    hit_cnt_d  = hit_cnt_q;
    miss_cnt_d = miss_cnt_q;
    if (clear) begin
      hit_cnt_d  = '0;
      miss_cnt_d = '0;
    end else begin
      // writing a counter offset preloads it
      if (wr && (ctrl_addr_i == CTRL_HIT_CNT)) begin
        hit_cnt_d = ctrl_wdata_i[CNT_W-1:0];
      end else if (hit_i && (hit_cnt_q != '1)) begin
        hit_cnt_d = hit_cnt_q + 1'b1;
      end
      if (wr && (ctrl_addr_i == CTRL_MISS_CNT)) begin
        miss_cnt_d = ctrl_wdata_i[CNT_W-1:0];
      end else if (miss_i && (miss_cnt_q != '1)) begin
        miss_cnt_d = miss_cnt_q + 1'b1;
      end
    end
  end

  // Counter registers read back zero-extended
  // Next values, so a hit that acks in the same cycle is included
  always_comb begin
    case (ctrl_addr_i)
      CTRL_HIT_CNT:  rdata = {{(DATA_W-CNT_W){1'b0}}, hit_cnt_d};
      CTRL_MISS_CNT: rdata = {{(DATA_W-CNT_W){1'b0}}, miss_cnt_d};
      default:       rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hit_cnt_q    <= '0;
      miss_cnt_q   <= '0;
      ctrl_ack_o   <= 1'b0;
      invalidate_o <= 1'b0;
    end else begin
      ctrl_ack_o   <= ctrl_req_i;
      invalidate_o <= wr && (ctrl_addr_i == CTRL_INVALIDATE);
      hit_cnt_q    <= hit_cnt_d;
      miss_cnt_q   <= miss_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) begin
      ctrl_rdata_o <= rdata;
    end
  end

endmodule

/* verilog/cache_top.sv */
module cache_top import cache_pkg::*; (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // Processor bus
  input  logic     iob_valid_i,
  input  addr_t    iob_addr_i,
  input  data_t    iob_wdata_i,
  input  strb_t    iob_wstrb_i,
  output logic     iob_rvalid_o,
  output data_t    iob_rdata_o,
  output logic     iob_ready_o,
  // External memory
  output logic     mem_req_o,
  output mem_req_t mem_o,
  input  logic     mem_ack_i,
  input  data_t    mem_rdata_i
);

  logic       data_req;
  cache_req_t data_req_pl;
  logic       data_ack;
  data_t      data_rdata;

  logic       ctrl_req;
  ctrl_addr_t ctrl_addr;
  logic       ctrl_we;
  data_t      ctrl_wdata;
  logic       ctrl_ack;
  data_t      ctrl_rdata;

  logic       be_req;
  mem_req_t   be_req_pl;
  logic       be_ack;
  data_t      be_rdata;

  logic       hit;
  logic       miss;
  logic       invalidate;

  cache_front_end front_end_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .iob_valid_i  (iob_valid_i),
    .iob_addr_i   (iob_addr_i),
    .iob_wdata_i  (iob_wdata_i),
    .iob_wstrb_i  (iob_wstrb_i),
    .iob_rvalid_o (iob_rvalid_o),
    .iob_rdata_o  (iob_rdata_o),
    .iob_ready_o  (iob_ready_o),
    .data_req_o   (data_req),
    .data_o       (data_req_pl),
    .data_rdata_i (data_rdata),
    .data_ack_i   (data_ack),
    .ctrl_req_o   (ctrl_req),
    .ctrl_addr_o  (ctrl_addr),
    .ctrl_we_o    (ctrl_we),
    .ctrl_wdata_o (ctrl_wdata),
    .ctrl_rdata_i (ctrl_rdata),
    .ctrl_ack_i   (ctrl_ack)
  );

  cache_memory memory_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .data_req_i   (data_req),
    .data_i       (data_req_pl),
    .data_ack_o   (data_ack),
    .data_rdata_o (data_rdata),
    .be_req_o     (be_req),
    .be_o         (be_req_pl),
    .be_ack_i     (be_ack),
    .be_rdata_i   (be_rdata),
    .invalidate_i (invalidate),
    .hit_o        (hit),
    .miss_o       (miss)
  );

  cache_back_end back_end_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .be_req_i    (be_req),
    .be_i        (be_req_pl),
    .be_ack_o    (be_ack),
    .be_rdata_o  (be_rdata),
    .mem_req_o   (mem_req_o),
    .mem_o       (mem_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

  cache_control control_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ctrl_req_i   (ctrl_req),
    .ctrl_addr_i  (ctrl_addr),
    .ctrl_we_i    (ctrl_we),
    .ctrl_wdata_i (ctrl_wdata),
    .ctrl_ack_o   (ctrl_ack),
    .ctrl_rdata_o (ctrl_rdata),
    .hit_i        (hit),
    .miss_i       (miss),
    .invalidate_o (invalidate)
  );

endmodule

/* testbench/tb_mem_model.sv */
module tb_mem_model import cache_pkg::*; (
  input  logic       clk_i,
  input  logic       mem_req_i,
  input  mem_req_t   mem_i,
  input  logic [1:0] lat_i,
  output logic       mem_ack_o,
  output data_t      mem_rdata_o,
  output mem_req_t   last_req_o
);

  timeunit 1ns;
  timeprecision 1ps;

  data_t      mem [2**MEM_ADDR_W];
  logic       busy;
  logic [1:0] wait_cnt;

  // Every word starts as a function of its full address
  function automatic data_t fill_word(input mem_addr_t a);
    return {2'b10, ~a, a};
  endfunction

  // Backdoor read
  function automatic data_t peek(input mem_addr_t a);
    return mem[a];
  endfunction

  initial begin
    busy        = 1'b0;
    wait_cnt    = '0;
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    last_req_o  = '0;
    for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
      mem[mem_addr_t'(a)] = fill_word(mem_addr_t'(a));
    end
    forever begin
      @(posedge clk_i);
      #2;
      if (mem_ack_o) begin
        // Ack lasts one cycle
        mem_ack_o = 1'b0;
      end else if (mem_req_i) begin
        if (!busy) begin
          busy     = 1'b1;
          wait_cnt = lat_i;
        end
        if (wait_cnt != '0) begin
          wait_cnt = wait_cnt - 2'd1;
        end else begin
          busy       = 1'b0;
          last_req_o = mem_i;
          if (mem_i.we) begin
            for (int b = 0; b < STRB_W; b++) begin
              if (mem_i.wstrb[b]) begin
                mem[mem_i.addr][8*b +: 8] = mem_i.wdata[8*b +: 8];
              end
            end
          end
          mem_rdata_o = mem[mem_i.addr];
          mem_ack_o   = 1'b1;
        end
      end
    end
  end

endmodule

/* testbench/cache_tb.sv */
module cache_tb import cache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int RANDOM_OPS     = 40;

  logic       clk;
  logic       arst_n;
  logic       iob_valid;
  addr_t      iob_addr;
  data_t      iob_wdata;
  strb_t      iob_wstrb;
  logic       iob_rvalid;
  data_t      iob_rdata;
  logic       iob_ready;
  logic       mem_req;
  mem_req_t   mem_req_pl;
  logic       mem_ack;
  data_t      mem_rdata;
  logic [1:0] mem_lat;
  mem_req_t   last_mem_req;

  logic [15:0] lfsr_q;
  int          check_count;
  int          error_count;
  int          test_count;
  int          failed_tests;

  // Expected memory contents and tag store
  data_t            shadow_mem [mem_addr_t];
  logic [LINES-1:0] shadow_valid;
  tag_t             shadow_tag [LINES];
  cnt_t             exp_hits;
  cnt_t             exp_misses;

  cache_top cache_top_inst (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .iob_valid_i  (iob_valid),
    .iob_addr_i   (iob_addr),
    .iob_wdata_i  (iob_wdata),
    .iob_wstrb_i  (iob_wstrb),
    .iob_rvalid_o (iob_rvalid),
    .iob_rdata_o  (iob_rdata),
    .iob_ready_o  (iob_ready),
    .mem_req_o    (mem_req),
    .mem_o        (mem_req_pl),
    .mem_ack_i    (mem_ack),
    .mem_rdata_i  (mem_rdata)
  );

  tb_mem_model mem_model_inst (
    .clk_i       (clk),
    .mem_req_i   (mem_req),
    .mem_i       (mem_req_pl),
    .lat_i       (mem_lat),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata),
    .last_req_o  (last_mem_req)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return bits;
  endfunction

  function automatic addr_t ctrl_addr(input ctrl_addr_t off);
    return {1'b1, {(ADDR_W-1-CTRL_ADDR_W){1'b0}}, off};
  endfunction

  // Untouched words still hold their initial fill
  function automatic data_t expected_word(input mem_addr_t a);
    if (shadow_mem.exists(a)) begin
      return shadow_mem[a];
    end
    return mem_model_inst.fill_word(a);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t w;
    w = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return w;
  endfunction

  // Direct-mapped lookup, fills the line on a miss
  task automatic shadow_read(input mem_addr_t a);
    index_t idx;
    tag_t   tg;
    idx = a[INDEX_W-1:0];
    tg  = a[MEM_ADDR_W-1:INDEX_W];
    if (shadow_valid[idx] && (shadow_tag[idx] == tg)) begin
      exp_hits = exp_hits + 1'b1;
    end else begin
      exp_misses        = exp_misses + 1'b1;
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx]   = tg;
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0d ns: the DUT never answered while waiting for %s", $time, what);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  // Request already driven, accepted on the edge after ready is seen
  task automatic wait_accept(input string what);
    int cycles;
    cycles = 0;
    while (!iob_ready) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_on_timeout(what);
      end
      cycles++;
      next_cycle();
    end
    next_cycle();
    iob_valid = 1'b0;
    iob_wstrb = '0;
  endtask

  task automatic bus_read(input addr_t a, output data_t d);
    int cycles;
    mem_lat   = 2'(lfsr_bits(2));
    iob_valid = 1'b1;
    iob_addr  = a;
    iob_wdata = '0;
    iob_wstrb = '0;
    wait_accept("read acceptance");
    cycles = 0;
    while (!iob_rvalid) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_on_timeout("read data");
      end
      cycles++;
      next_cycle();
    end
    d = iob_rdata;
  endtask

  // Writes must finish without read data valid
  task automatic bus_write(input addr_t a, input data_t wd, input strb_t st);
    int   cycles;
    logic rvalid_seen;
    mem_lat   = 2'(lfsr_bits(2));
    iob_valid = 1'b1;
    iob_addr  = a;
    iob_wdata = wd;
    iob_wstrb = st;
    wait_accept("write acceptance");
    cycles      = 0;
    rvalid_seen = 1'b0;
    while (!iob_ready) begin
      if (cycles == TIMEOUT_CYCLES) begin
        stop_on_timeout("write completion");
      end
      if (iob_rvalid) begin
        rvalid_seen = 1'b1;
      end
      cycles++;
      next_cycle();
    end
    check_count++;
    if (rvalid_seen || iob_rvalid) begin
      error_count++;
      $display("Read data valid was raised during the write to %h at %0d ns", a, $time);
    end
  endtask

  task automatic read_and_check(input mem_addr_t a);
    data_t d;
    data_t exp;
    exp = expected_word(a);
    bus_read({1'b0, a}, d);
    shadow_read(a);
    check_data($sformatf("iob_rdata_o[%h]", a), d, exp);
  endtask

  task automatic write_and_track(input mem_addr_t a, input data_t wd, input strb_t st);
    data_t    exp;
    mem_req_t exp_req;
    exp           = merge_bytes(expected_word(a), wd, st);
    exp_req.addr  = a;
    exp_req.wdata = wd;
    exp_req.wstrb = st;
    exp_req.we    = 1'b1;
    bus_write({1'b0, a}, wd, st);
    shadow_mem[a] = exp;
    check_mem_req("mem_o", last_mem_req, exp_req);
    check_data($sformatf("memory word %h", a), mem_model_inst.peek(a), exp);
  endtask

  task automatic check_counters();
    data_t d;
    bus_read(ctrl_addr(CTRL_HIT_CNT), d);
    check_cnt("hit counter", d[CNT_W-1:0], exp_hits);
    bus_read(ctrl_addr(CTRL_MISS_CNT), d);
    check_cnt("miss counter", d[CNT_W-1:0], exp_misses);
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("test %0d %s: pass", test_count, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: fail, %0d errors", test_count, name, error_count - errs_before);
    end
  endtask

  task automatic test_read_miss_hit();
    int errs;
    errs = error_count;
    read_and_check(15'h0123);
    read_and_check(15'h0123);
    check_counters();
    report_test("read miss then hit", errs);
  endtask

  task automatic test_partial_write();
    int errs;
    errs = error_count;
    // Cached line first, then one that is not
    write_and_track(15'h0123, 32'hA5A5_5A5A, 4'b0101);
    read_and_check(15'h0123);
    write_and_track(15'h2456, 32'h1234_5678, 4'b1010);
    read_and_check(15'h2456);
    check_counters();
    report_test("partial write", errs);
  endtask

  task automatic test_invalidate();
    int errs;
    errs = error_count;
    bus_write(ctrl_addr(CTRL_INVALIDATE), 32'h1, 4'hF);
    shadow_valid = '0;
    read_and_check(15'h0123);
    read_and_check(15'h2456);
    check_counters();
    report_test("invalidate", errs);
  endtask

  task automatic test_counter_clear();
    int errs;
    errs = error_count;
    bus_write(ctrl_addr(CTRL_CNT_CLEAR), 32'h1, 4'hF);
    exp_hits   = '0;
    exp_misses = '0;
    check_counters();
    report_test("counter clear", errs);
  endtask

  task automatic test_random_mix();
    int        errs;
    mem_addr_t a;
    data_t     wd;
    strb_t     st;
    errs = error_count;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      // Four tags over two neighbouring lines
      a = {7'd5, 2'(lfsr_bits(2)), 5'd9, 1'(lfsr_bits(1))};
      if (lfsr_bits(1) == 32'd1) begin
        wd = lfsr_bits(32);
        st = 4'(lfsr_bits(4));
        if (st == '0) begin
          st = '1;
        end
        write_and_track(a, wd, st);
      end else begin
        read_and_check(a);
      end
    end
    check_counters();
    report_test("random aliased mix", errs);
  endtask

  initial begin
    lfsr_q       = 16'd5;
    check_count  = 0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    shadow_valid = '0;
    exp_hits     = '0;
    exp_misses   = '0;
    arst_n       = 1'b0;
    iob_valid    = 1'b0;
    iob_addr     = '0;
    iob_wdata    = '0;
    iob_wstrb    = '0;
    mem_lat      = '0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    next_cycle();
    test_read_miss_hit();
    test_partial_write();
    test_invalidate();
    test_counter_clear();
    test_random_mix();
    $display("%0d tests, %0d failed; %0d checks, %0d errors",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/cache_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_back_end.sv
verilog/cache_control.sv
verilog/cache_top.sv
testbench/tb_mem_model.sv
testbench/cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cache_tb -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

output=$(./obj_dir/Vcache_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
